// File: Bender.yml
package:
  name: cgra_corner_tile

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cgra_pkg.sv
      - rtl/tile_config_regs.sv
      - rtl/switch_box_corner.sv
      - rtl/connection_box.sv
      - rtl/bit_pe.sv
      - rtl/cgra_corner_tile.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/cgra_tile_sva.sv
      - test/tb_cgra_corner_tile.sv

// File: rtl/bit_pe.sv
`timescale 1ns/100ps

module bit_pe (
	input  logic              clk,
	input  logic              reset,
	input  logic              a_i,
	input  logic              b_i,
	input  cgra_pkg::pe_cfg_t pe_cfg_i,
	output logic              pe_out_o
);

	import cgra_pkg::*;

	logic result;
	logic result_q;

	always_comb begin
		case (pe_cfg_i.op)
			PE_AND:  result = a_i & b_i;
			PE_OR:   result = a_i | b_i;
			PE_XOR:  result = a_i ^ b_i;
			PE_NOTA: result = ~a_i; // b is ignored.
			default: result = 1'b0;
		endcase
	end

	// captured every cycle, reg_out only picks which one leaves.
	always_ff @(posedge clk) begin
		if (reset)
			result_q <= 1'b0;
		else
			result_q <= result;
	end

	assign pe_out_o = pe_cfg_i.reg_out ? result_q : result;

endmodule

// File: rtl/cgra_consts.svh
`ifndef CGRA_CONSTS_SVH
`define CGRA_CONSTS_SVH

// configuration bus widths.
`define CFG_WIDTH      32
`define CFG_ADDR_WIDTH 2

// block addresses, address 3 is unused.
`define CFG_ADDR_SB 2'd0
`define CFG_ADDR_CB 2'd1
`define CFG_ADDR_PE 2'd2

// switch-box route codes, code 1 drives 0.
`define ROUTE_STRAIGHT 2'd0
`define ROUTE_CROSS    2'd2
`define ROUTE_PE       2'd3

// processing element opcodes.
`define PE_OP_AND  2'd0
`define PE_OP_OR   2'd1
`define PE_OP_XOR  2'd2
`define PE_OP_NOTA 2'd3

`endif

// File: rtl/cgra_corner_tile.sv
`timescale 1ns/100ps

module cgra_corner_tile (
	input  logic                  clk,
	input  logic                  reset,
	input  cgra_pkg::cfg_write_t  cfg_i,
	input  cgra_pkg::track_side_t in_side2_i,
	input  cgra_pkg::track_side_t in_side3_i,
	output cgra_pkg::track_side_t out_side2_o,
	output cgra_pkg::track_side_t out_side3_o,
	output logic                  pe_out_o
);

	import cgra_pkg::*;

	sb_cfg_t sb_cfg;
	cb_cfg_t cb_cfg;
	pe_cfg_t pe_cfg;

	logic op_a;
	logic op_b;
	logic pe_out;

	tile_config_regs u_cfg (
		.clk      (clk),
		.reset    (reset),
		.cfg_i    (cfg_i),
		.sb_cfg_o (sb_cfg),
		.cb_cfg_o (cb_cfg),
		.pe_cfg_o (pe_cfg)
	);

	connection_box u_cb (
		.in_side2_i (in_side2_i),
		.in_side3_i (in_side3_i),
		.cb_cfg_i   (cb_cfg),
		.a_o        (op_a),
		.b_o        (op_b)
	);

	bit_pe u_pe (
		.clk      (clk),
		.reset    (reset),
		.a_i      (op_a),
		.b_i      (op_b),
		.pe_cfg_i (pe_cfg),
		.pe_out_o (pe_out)
	);

	// pe output loops back into the switch box.
	switch_box_corner u_sb (
		.in_side2_i  (in_side2_i),
		.in_side3_i  (in_side3_i),
		.pe_out_i    (pe_out),
		.sb_cfg_i    (sb_cfg),
		.out_side2_o (out_side2_o),
		.out_side3_o (out_side3_o)
	);

	assign pe_out_o = pe_out;

endmodule

// File: rtl/cgra_pkg.sv
`include "cgra_consts.svh"

package cgra_pkg;

	// four single-bit tracks on one side of the tile.
	typedef logic [3:0] track_side_t;

	// per-track route code.
	typedef logic [1:0] route_sel_t;

	// side2_sel sits in the low byte, entry k at bits 2k+1:2k.
	typedef struct packed {
		route_sel_t [3:0] side3_sel;
		route_sel_t [3:0] side2_sel;
	} sb_cfg_t;

	// 0..3 pick side 2 tracks, 4..7 pick side 3 tracks.
	typedef struct packed {
		logic [2:0] sel_b;
		logic [2:0] sel_a;
	} cb_cfg_t;

	typedef enum logic [1:0] {
		PE_AND  = `PE_OP_AND,
		PE_OR   = `PE_OP_OR,
		PE_XOR  = `PE_OP_XOR,
		PE_NOTA = `PE_OP_NOTA
	} pe_op_e;

	typedef struct packed {
		logic   reg_out; // bit 2.
		pe_op_e op;      // bits 1:0.
	} pe_cfg_t;

	// configuration write bus.
	typedef struct packed {
		logic                       en;
		logic [`CFG_ADDR_WIDTH-1:0] addr;
		logic [`CFG_WIDTH-1:0]      data;
	} cfg_write_t;

endpackage

// File: rtl/connection_box.sv
`timescale 1ns/100ps

module connection_box (
	input  cgra_pkg::track_side_t in_side2_i,
	input  cgra_pkg::track_side_t in_side3_i,
	input  cgra_pkg::cb_cfg_t     cb_cfg_i,
	output logic                  a_o,
	output logic                  b_o
);

	import cgra_pkg::*;

	localparam int TRACKS = $bits(track_side_t);

	// side 2 in the low half so selects 0..3 land on it.
	logic [2*TRACKS-1:0] cand;

	logic a_pick;
	logic b_pick;

	assign cand = {in_side3_i, in_side2_i};

	always_comb begin
		a_pick = cand[cb_cfg_i.sel_a];
		b_pick = cand[cb_cfg_i.sel_b];
	end

	assign a_o = a_pick;
	assign b_o = b_pick;

endmodule

// File: rtl/switch_box_corner.sv
`timescale 1ns/100ps
`include "cgra_consts.svh"

module switch_box_corner (
	input  cgra_pkg::track_side_t in_side2_i,
	input  cgra_pkg::track_side_t in_side3_i,
	input  logic                  pe_out_i,
	input  cgra_pkg::sb_cfg_t     sb_cfg_i,
	output cgra_pkg::track_side_t out_side2_o,
	output cgra_pkg::track_side_t out_side3_o
);

	import cgra_pkg::*;

	localparam int TRACKS = $bits(track_side_t);

	// side 2 outputs take side 3 tracks rotated by two.
	for (genvar k = 0; k < TRACKS; k++) begin : g_side2
		localparam int SRC = (k + 2) % TRACKS;

		route_sel_t sel;
		logic       route_bit;

		assign sel = sb_cfg_i.side2_sel[k];

		always_comb begin
			case (sel)
				`ROUTE_STRAIGHT: route_bit = in_side3_i[SRC];
				`ROUTE_PE:       route_bit = pe_out_i;
				default:         route_bit = 1'b0; // codes 1 and 2 unused here.
			endcase
		end

		assign out_side2_o[k] = route_bit;
	end

	// side 3 outputs take side 2 tracks rotated by one.
	for (genvar k = 0; k < TRACKS; k++) begin : g_side3
		localparam int SRC = (k + 1) % TRACKS;

		route_sel_t sel;
		logic       route_bit;

		assign sel = sb_cfg_i.side3_sel[k];

		always_comb begin
			case (sel)
				`ROUTE_CROSS: route_bit = in_side2_i[SRC];
				`ROUTE_PE:    route_bit = pe_out_i;
				default:      route_bit = 1'b0; // codes 0 and 1.
			endcase
		end

		assign out_side3_o[k] = route_bit;
	end

endmodule

// File: rtl/tile_config_regs.sv
`timescale 1ns/100ps
`include "cgra_consts.svh"

module tile_config_regs (
	input  logic               clk,
	input  logic               reset,
	input  cgra_pkg::cfg_write_t cfg_i,
	output cgra_pkg::sb_cfg_t  sb_cfg_o,
	output cgra_pkg::cb_cfg_t  cb_cfg_o,
	output cgra_pkg::pe_cfg_t  pe_cfg_o
);

	import cgra_pkg::*;

	localparam int SB_BITS = $bits(sb_cfg_t);
	localparam int CB_BITS = $bits(cb_cfg_t);
	localparam int PE_BITS = $bits(pe_cfg_t);

	logic sb_we;
	logic cb_we;
	logic pe_we;

	sb_cfg_t sb_q;
	cb_cfg_t cb_q;
	pe_cfg_t pe_q;

	// one-hot write decode, address 3 hits nothing.
	always_comb begin
		sb_we = 1'b0;
		cb_we = 1'b0;
		pe_we = 1'b0;
		if (cfg_i.en) begin
			case (cfg_i.addr)
				`CFG_ADDR_SB: sb_we = 1'b1;
				`CFG_ADDR_CB: cb_we = 1'b1;
				`CFG_ADDR_PE: pe_we = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sb_q <= '0;
			cb_q <= '0;
			pe_q <= '0;
		end else begin
			if (sb_we)
				sb_q <= sb_cfg_t'(cfg_i.data[SB_BITS-1:0]); // low 16 bits.
			if (cb_we)
				cb_q <= cb_cfg_t'(cfg_i.data[CB_BITS-1:0]);
			if (pe_we)
				pe_q <= pe_cfg_t'(cfg_i.data[PE_BITS-1:0]);
		end
	end

	assign sb_cfg_o = sb_q;
	assign cb_cfg_o = cb_q;
	assign pe_cfg_o = pe_q;

endmodule

// File: test/cgra_tile_sva.sv
`timescale 1ns/100ps
`include "cgra_consts.svh"

module cgra_tile_sva (
	input logic                 clk,
	input logic                 reset,
	input cgra_pkg::cfg_write_t cfg_i,
	input cgra_pkg::sb_cfg_t    sb_cfg,
	input cgra_pkg::cb_cfg_t    cb_cfg,
	input cgra_pkg::pe_cfg_t    pe_cfg,
	input logic                 op_a,
	input logic                 op_b,
	input logic                 pe_out
);

	import cgra_pkg::*;

	int   assert_fails = 0;
	logic fn_now;
	logic pe_wr;
	logic null_wr;

	assign fn_now  = (pe_cfg.op == PE_AND) ? (op_a & op_b) :
		(pe_cfg.op == PE_OR) ? (op_a | op_b) :
		(pe_cfg.op == PE_XOR) ? (op_a ^ op_b) : !op_a;
	assign pe_wr   = cfg_i.en && (cfg_i.addr == `CFG_ADDR_PE);
	assign null_wr = cfg_i.en && (cfg_i.addr == 2'd3);

	pe_write_lands: assert property (@(posedge clk) disable iff (reset)
		pe_wr |=> pe_cfg == $past(cfg_i.data[$bits(pe_cfg_t)-1:0]))
	else begin
		assert_fails++;
		$error("pe config write did not take effect on the next cycle");
	end

	// result_q follows last cycle's function in registered mode.
	pe_registered: assert property (@(posedge clk) disable iff (reset)
		(pe_cfg.reg_out && !$past(reset)) |-> pe_out == $past(fn_now))
	else begin
		assert_fails++;
		$error("registered pe output differs from last cycle's result");
	end

	addr3_ignored: assert property (@(posedge clk) disable iff (reset)
		null_wr |=> $stable(sb_cfg) && $stable(cb_cfg) && $stable(pe_cfg))
	else begin
		assert_fails++;
		$error("write to address 3 changed a config register");
	end

endmodule

// File: test/tb_cgra_corner_tile.sv
`timescale 1ns/100ps
`include "cgra_consts.svh"

module tb_cgra_corner_tile;

	import cgra_pkg::*;

	logic        clk;
	logic        reset;
	cfg_write_t  cfg;
	track_side_t in_side2;
	track_side_t in_side3;
	track_side_t out_side2;
	track_side_t out_side3;
	logic        pe_out;

	// shadow copy of the tile registers.
	sb_cfg_t     m_sb;
	cb_cfg_t     m_cb;
	pe_cfg_t     m_pe;
	logic        m_pe_q; // model of the pe output register.

	logic [31:0] rng;
	track_side_t last_side2;
	track_side_t last_side3;
	logic        last_pe;

	cgra_corner_tile uut (
		.clk         (clk),
		.reset       (reset),
		.cfg_i       (cfg),
		.in_side2_i  (in_side2),
		.in_side3_i  (in_side3),
		.out_side2_o (out_side2),
		.out_side3_o (out_side3),
		.pe_out_o    (pe_out)
	);

	bind cgra_corner_tile cgra_tile_sva u_sva (
		.clk    (clk),
		.reset  (reset),
		.cfg_i  (cfg_i),
		.sb_cfg (sb_cfg),
		.cb_cfg (cb_cfg),
		.pe_cfg (pe_cfg),
		.op_a   (op_a),
		.op_b   (op_b),
		.pe_out (pe_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic cfg_write_t make_write(input logic en, input logic [1:0] addr,
			input logic [31:0] data);
		cfg_write_t w;
		w.en   = en;
		w.addr = addr;
		w.data = data;
		return w;
	endfunction

	function automatic logic pick_track(input logic [2:0] sel, input track_side_t s2,
			input track_side_t s3);
		return sel[2] ? s3[sel[1:0]] : s2[sel[1:0]];
	endfunction

	function automatic logic pe_model(input logic [1:0] op, input logic a, input logic b);
		case (op)
			`PE_OP_AND: return a & b;
			`PE_OP_OR:  return a | b;
			`PE_OP_XOR: return a ^ b;
			default:    return !a;
		endcase
	endfunction

	function automatic track_side_t route_side2(input sb_cfg_t sb, input track_side_t s3,
			input logic pe);
		track_side_t o;
		for (int k = 0; k < 4; k++)
			o[k] = (sb.side2_sel[k] == `ROUTE_STRAIGHT) ? s3[(k + 2) % 4] :
				(sb.side2_sel[k] == `ROUTE_PE) ? pe : 1'b0;
		return o;
	endfunction

	function automatic track_side_t route_side3(input sb_cfg_t sb, input track_side_t s2,
			input logic pe);
		track_side_t o;
		for (int k = 0; k < 4; k++)
			o[k] = (sb.side3_sel[k] == `ROUTE_CROSS) ? s2[(k + 1) % 4] :
				(sb.side3_sel[k] == `ROUTE_PE) ? pe : 1'b0;
		return o;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic wait_outputs_known(input int limit);
		int n;
		n = 0;
		while ($isunknown({out_side2, out_side3, pe_out})) begin
			if (n == limit) begin
				$display("tile outputs still unknown %0d cycles after reset", limit);
				$display("Test failed");
				$fatal(1, "reset timeout");
			end else begin
				@(posedge clk);
				#2;
				n++;
			end
		end
	endtask

	// drive one cycle, check mid-cycle, then advance the model past the edge.
	task automatic run_cycle(input string name, input cfg_write_t w, input track_side_t s2,
			input track_side_t s3);
		logic comb;
		logic exp_pe;
		cfg      = w;
		in_side2 = s2;
		in_side3 = s3;
		#10;
		comb   = pe_model(m_pe.op, pick_track(m_cb.sel_a, s2, s3),
			pick_track(m_cb.sel_b, s2, s3));
		exp_pe = m_pe.reg_out ? m_pe_q : comb;
		check({name, " pe_out"}, exp_pe, pe_out);
		check({name, " side2"}, route_side2(m_sb, s3, exp_pe), out_side2);
		check({name, " side3"}, route_side3(m_sb, s2, exp_pe), out_side3);
		last_side2 = out_side2;
		last_side3 = out_side3;
		last_pe    = pe_out;
		m_pe_q = comb;
		if (w.en) begin
			case (w.addr)
				`CFG_ADDR_SB: m_sb = w.data[15:0];
				`CFG_ADDR_CB: m_cb = w.data[5:0];
				`CFG_ADDR_PE: m_pe = w.data[2:0];
				default: ;
			endcase
		end
		@(posedge clk);
		#2;
	endtask

	task automatic test_reset_state();
		logic [31:0] r;
		track_side_t s2;
		track_side_t s3;
		for (int i = 0; i < 4; i++) begin
			r = next_rand();
			s2 = r[3:0];
			s3 = r[7:4];
			cfg = '0;
			in_side2 = s2;
			in_side3 = s3;
			#10;
			check("reset side2", {s3[1], s3[0], s3[3], s3[2]}, out_side2);
			check("reset side3", 4'h0, out_side3);
			check("reset pe_out", s2[0], pe_out); // and of track 0 with itself.
			m_pe_q = s2[0];
			@(posedge clk);
			#2;
		end
	endtask

	task automatic test_routing();
		logic [31:0] r;
		run_cycle("routing setup", make_write(1'b1, `CFG_ADDR_PE, 32'h2), '0, '0);
		run_cycle("routing setup", make_write(1'b1, `CFG_ADDR_CB, 32'h20), '0, '0);
		for (int c = 0; c < 4; c++) begin
			r = next_rand();
			run_cycle("routing fixed", make_write(1'b1, `CFG_ADDR_SB, {16'h0, {8{c[1:0]}}}),
				r[3:0], r[7:4]);
		end
		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			run_cycle("routing random", make_write(1'b1, `CFG_ADDR_SB, r), r[19:16], r[23:20]);
		end
	endtask

	task automatic test_cb_pe();
		logic [31:0] r;
		logic [31:0] t;
		for (int i = 0; i < 60; i++) begin
			r = next_rand();
			t = next_rand();
			if (i % 2)
				run_cycle("cb select", make_write(1'b1, `CFG_ADDR_CB, r), t[3:0], t[7:4]);
			else
				run_cycle("pe opcode", make_write(1'b1, `CFG_ADDR_PE, r & ~32'h4), t[3:0], t[7:4]);
		end
	endtask

	task automatic test_registered();
		logic [31:0] r;
		logic [31:0] t;
		r = next_rand();
		run_cycle("reg setup", make_write(1'b1, `CFG_ADDR_PE, (r & 32'h3) | 32'h4), r[11:8],
			r[15:12]);
		run_cycle("reg setup", make_write(1'b1, `CFG_ADDR_SB, 32'hffff), r[19:16], r[23:20]);
		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			t = next_rand();
			if (i % 8 == 3)
				run_cycle("reg mode", make_write(1'b1, `CFG_ADDR_CB, r), t[3:0], t[7:4]);
			else if (i % 8 == 7)
				run_cycle("reg mode", make_write(1'b1, `CFG_ADDR_PE, r | 32'h4), t[3:0], t[7:4]);
			else
				run_cycle("reg mode", make_write(1'b0, 2'd0, r), t[3:0], t[7:4]);
		end
	endtask

	task automatic test_write_timing();
		logic [31:0] r;
		logic [31:0] t;
		track_side_t save_side2;
		track_side_t save_side3;
		logic        save_pe;
		logic [1:0]  addr;
		r = next_rand();
		run_cycle("hold", make_write(1'b0, 2'd0, 32'h0), r[3:0], r[7:4]);
		run_cycle("hold", make_write(1'b0, 2'd0, 32'h0), r[3:0], r[7:4]);
		// outputs the model predicts for the held tracks and settings.
		save_pe    = m_pe.reg_out ? m_pe_q : pe_model(m_pe.op,
			pick_track(m_cb.sel_a, r[3:0], r[7:4]), pick_track(m_cb.sel_b, r[3:0], r[7:4]));
		save_side2 = route_side2(m_sb, r[7:4], save_pe);
		save_side3 = route_side3(m_sb, r[3:0], save_pe);
		run_cycle("addr3 write", make_write(1'b1, 2'd3, next_rand()), r[3:0], r[7:4]);
		run_cycle("after addr3", make_write(1'b0, 2'd0, 32'h0), r[3:0], r[7:4]);
		check("addr3 side2", save_side2, last_side2);
		check("addr3 side3", save_side3, last_side3);
		check("addr3 pe_out", save_pe, last_pe);
		for (int i = 0; i < 30; i++) begin
			r = next_rand();
			t = next_rand();
			addr = (t[9:8] == 2'd3) ? `CFG_ADDR_SB : t[9:8];
			run_cycle("write timing", make_write(1'b1, addr, r), t[3:0], t[7:4]);
		end
	endtask

	task automatic test_long_random();
		logic [31:0] r;
		logic [31:0] t;
		for (int i = 0; i < 400; i++) begin
			r = next_rand();
			t = next_rand();
			run_cycle("long random", make_write(t[12], t[14:13], r), t[3:0], t[7:4]);
		end
	endtask

	initial begin
		reset    = 1'b1;
		cfg      = '0;
		in_side2 = '0;
		in_side3 = '0;
		rng      = 32'd13163;
		m_sb     = '0;
		m_cb     = '0;
		m_pe     = '0;
		m_pe_q   = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		wait_outputs_known(4);
		test_reset_state();
		test_routing();
		test_cb_pe();
		test_registered();
		test_write_timing();
		test_long_random();
		if (uut.u_sva.assert_fails != 0) begin
			$display("an assertion fired %0d times", uut.u_sva.assert_fails);
			$display("Test failed");
			$fatal(1, "run ended with errors");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// File: verilog.f
+incdir+rtl
rtl/cgra_pkg.sv
rtl/tile_config_regs.sv
rtl/switch_box_corner.sv
rtl/connection_box.sv
rtl/bit_pe.sv
rtl/cgra_corner_tile.sv
test/cgra_tile_sva.sv
test/tb_cgra_corner_tile.sv
